/* common/pk_decode_macros.svh */
// Protocol sizes and host address map for the t1 decoder, included by the RTL and testbench
`ifndef PK_DECODE_MACROS_SVH
`define PK_DECODE_MACROS_SVH

// ==================================================
// ML-DSA-87 t1 geometry
// ==================================================
`define PKD_K            8
`define PKD_N            256
`define PKD_COEFF_IN_W   10
`define PKD_COEFF_OUT_W  24
`define PKD_SHIFT        13
`define PKD_LANES        8
`define PKD_KEY_WORDS    ((`PKD_K * `PKD_N) / `PKD_LANES)
`define PKD_KEY_AW       8

// Coefficient memory holds four coefficients per entry
`define PKD_MEM_DEPTH    1024
`define PKD_MEM_AW       10

// ==================================================
// Wishbone host port
// ==================================================
`define PKD_WB_AW        14
// Region select in wb_adr[13:12]
`define PKD_REGION_REG   2'd0
`define PKD_REGION_KEY   2'd1
`define PKD_REGION_COEFF 2'd2

`endif

/* common/pk_decode_pkg.sv */
// Shared types for the t1 decoder datapath, imported by each RTL module
`default_nettype none
`include "pk_decode_macros.svh"

package pk_decode_pkg;

    // One key word, written raw by the host and read as coefficients by the unpacker
    typedef union packed {
        logic [`PKD_LANES*`PKD_COEFF_IN_W-1:0]       raw;
        // Lane 0 sits in the low bits
        logic [`PKD_LANES-1:0][`PKD_COEFF_IN_W-1:0] coeff;
    } t1_word_u;

    // Four decoded coefficients, one memory entry
    typedef logic [`PKD_LANES/2-1:0][`PKD_COEFF_OUT_W-1:0] coeff_quad_t;

    // Write request into one coefficient memory port
    typedef struct packed {
        logic                   wr_en;
        logic [`PKD_MEM_AW-1:0] addr;
    } mem_wr_req_t;

    // Single-cycle command pulses from the host registers
    typedef struct packed {
        logic                   start;
        logic                   zeroize;
        logic [`PKD_MEM_AW-1:0] dest_base;
    } dec_ctrl_t;

endpackage

`default_nettype wire

/* design/coeff_mem.sv */
// Decoded coefficient storage with two quad write ports and a single-lane host read port
`timescale 1ns/1ps
`default_nettype none
`include "pk_decode_macros.svh"

module coeff_mem
    import pk_decode_pkg::*;
(
    input  logic                        clk,
    input  mem_wr_req_t                 req_a,
    input  mem_wr_req_t                 req_b,
    input  coeff_quad_t                 wr_data_a,
    input  coeff_quad_t                 wr_data_b,
    input  logic [11:0]                 host_rd_idx,
    output logic [`PKD_COEFF_OUT_W-1:0] host_rd_coeff
);

    coeff_quad_t entries [`PKD_MEM_DEPTH];

    // Ports A and B never target the same entry in one cycle
    always_ff @(posedge clk) begin
        if (req_a.wr_en) begin
            entries[req_a.addr] <= wr_data_a;
        end
        if (req_b.wr_en) begin
            entries[req_b.addr] <= wr_data_b;
        end
    end

    // Entry is index/4, lane is index%4
    always_ff @(posedge clk) begin
        host_rd_coeff <= entries[host_rd_idx[11:2]][host_rd_idx[1:0]];
    end

endmodule

`default_nettype wire

/* design/key_buffer.sv */
// Packed t1 key word storage, loaded in slices by the host and streamed out to the decoder
`timescale 1ns/1ps
`default_nettype none
`include "pk_decode_macros.svh"

module key_buffer
    import pk_decode_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   key_wr_en,
    input  logic [`PKD_KEY_AW-1:0] key_wr_addr,
    input  logic [1:0]             key_wr_slice,
    input  logic [31:0]            key_wr_data,
    output t1_word_u               host_word,
    input  logic                   key_rd_en,
    input  logic [`PKD_KEY_AW-1:0] key_rd_addr,
    output t1_word_u               key_rd_data,
    output logic                   key_rd_valid,
    input  logic                   zeroize
);

    t1_word_u words [`PKD_KEY_WORDS];

    // One 32-bit slice per host write, top slice is 16 bits
    always_ff @(posedge clk) begin
        if (key_wr_en) begin
            case (key_wr_slice)
                2'd0:    words[key_wr_addr].raw[31:0]  <= key_wr_data;
                2'd1:    words[key_wr_addr].raw[63:32] <= key_wr_data;
                2'd2:    words[key_wr_addr].raw[79:64] <= key_wr_data[15:0];
                default: begin
                end
            endcase
        end
        if (key_rd_en) begin
            key_rd_data <= words[key_rd_addr];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            key_rd_valid <= 1'b0;
        end else begin
            key_rd_valid <= key_rd_en && !zeroize;
        end
    end

    assign host_word = words[key_wr_addr];

endmodule

`default_nettype wire

/* design/pk_decode_top.sv */
// Top level of the t1 decoder, tying the Wishbone host port to the buffers and decode pipeline
`timescale 1ns/1ps
`default_nettype none
`include "pk_decode_macros.svh"

module pk_decode_top
    import pk_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`PKD_WB_AW-1:0] wb_adr,
    input  logic [31:0]           wb_wdata,
    output logic [31:0]           wb_rdata,
    output logic                  wb_ack
);

    dec_ctrl_t                   ctrl;
    logic                        busy;
    logic                        done_pulse;
    logic                        key_wr_en;
    logic [`PKD_KEY_AW-1:0]      key_wr_addr;
    logic [1:0]                  key_wr_slice;
    logic [31:0]                 key_wr_data;
    t1_word_u                    host_word;
    t1_word_u                    key_rd_data;
    logic                        key_rd_en;
    logic [`PKD_KEY_AW-1:0]      key_rd_addr;
    logic                        key_rd_valid;
    logic [11:0]                 host_rd_idx;
    logic [`PKD_COEFF_OUT_W-1:0] host_rd_coeff;
    logic                        rd_active;
    logic                        read_last;
    logic [`PKD_MEM_AW-1:0]      base_addr;
    logic [`PKD_MEM_AW-1:0]      wr_offset;
    coeff_quad_t                 wr_data_a;
    coeff_quad_t                 wr_data_b;
    mem_wr_req_t                 req_a;
    mem_wr_req_t                 req_b;

    // ==================================================
    // Host side
    // ==================================================
    wb_host_regs u_wb_host_regs (
        .clk           (clk),
        .reset_n       (reset_n),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_wdata      (wb_wdata),
        .wb_rdata      (wb_rdata),
        .wb_ack        (wb_ack),
        .ctrl          (ctrl),
        .busy          (busy),
        .done_pulse    (done_pulse),
        .key_wr_en     (key_wr_en),
        .key_wr_addr   (key_wr_addr),
        .key_wr_slice  (key_wr_slice),
        .key_wr_data   (key_wr_data),
        .key_rd_word   (host_word),
        .host_rd_idx   (host_rd_idx),
        .host_rd_coeff (host_rd_coeff)
    );

    key_buffer u_key_buffer (
        .clk          (clk),
        .reset_n      (reset_n),
        .key_wr_en    (key_wr_en),
        .key_wr_addr  (key_wr_addr),
        .key_wr_slice (key_wr_slice),
        .key_wr_data  (key_wr_data),
        .host_word    (host_word),
        .key_rd_en    (key_rd_en),
        .key_rd_addr  (key_rd_addr),
        .key_rd_data  (key_rd_data),
        .key_rd_valid (key_rd_valid),
        .zeroize      (ctrl.zeroize)
    );

    // ==================================================
    // Decode pipeline
    // ==================================================
    pk_decode_fsm u_pk_decode_fsm (
        .clk          (clk),
        .reset_n      (reset_n),
        .ctrl         (ctrl),
        .read_last    (read_last),
        .key_rd_valid (key_rd_valid),
        .rd_active    (rd_active),
        .busy         (busy),
        .done_pulse   (done_pulse)
    );

    pk_decode_counter u_pk_decode_counter (
        .clk          (clk),
        .reset_n      (reset_n),
        .ctrl         (ctrl),
        .rd_active    (rd_active),
        .key_rd_valid (key_rd_valid),
        .key_rd_en    (key_rd_en),
        .key_rd_addr  (key_rd_addr),
        .read_last    (read_last),
        .base_addr    (base_addr),
        .wr_offset    (wr_offset)
    );

    t1_unpack u_t1_unpack (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (ctrl.zeroize),
        .key_rd_data  (key_rd_data),
        .key_rd_valid (key_rd_valid),
        .base_addr    (base_addr),
        .wr_offset    (wr_offset),
        .wr_data_a    (wr_data_a),
        .wr_data_b    (wr_data_b),
        .req_a        (req_a),
        .req_b        (req_b)
    );

    coeff_mem u_coeff_mem (
        .clk           (clk),
        .req_a         (req_a),
        .req_b         (req_b),
        .wr_data_a     (wr_data_a),
        .wr_data_b     (wr_data_b),
        .host_rd_idx   (host_rd_idx),
        .host_rd_coeff (host_rd_coeff)
    );

endmodule

`default_nettype wire

/* design/wb_host_regs.sv */
// Wishbone classic slave for the decoder, holding CTRL/STATUS and routing key and coefficient access
`timescale 1ns/1ps
`default_nettype none
`include "pk_decode_macros.svh"

module wb_host_regs
    import pk_decode_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`PKD_WB_AW-1:0]       wb_adr,
    input  logic [31:0]                 wb_wdata,
    output logic [31:0]                 wb_rdata,
    output logic                        wb_ack,
    output dec_ctrl_t                   ctrl,
    input  logic                        busy,
    input  logic                        done_pulse,
    output logic                        key_wr_en,
    output logic [`PKD_KEY_AW-1:0]      key_wr_addr,
    output logic [1:0]                  key_wr_slice,
    output logic [31:0]                 key_wr_data,
    input  t1_word_u                    key_rd_word,
    output logic [11:0]                 host_rd_idx,
    input  logic [`PKD_COEFF_OUT_W-1:0] host_rd_coeff
);

    logic       wb_req;
    logic [1:0] region;
    logic       ctrl_wr;
    logic       done;

    // New request seen when strobed and not already in the ack cycle
    assign wb_req  = wb_cyc && wb_stb && !wb_ack;
    assign region  = wb_adr[13:12];
    assign ctrl_wr = wb_req && wb_we && (region == `PKD_REGION_REG) && (wb_adr[11:0] == 12'd0);

    assign key_wr_en    = wb_req && wb_we && (region == `PKD_REGION_KEY);
    assign key_wr_addr  = wb_adr[9:2];
    assign key_wr_slice = wb_adr[1:0];
    assign key_wr_data  = wb_wdata;
    assign host_rd_idx  = wb_adr[11:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // Start is dropped while busy or when paired with zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl <= '0;
        end else begin
            ctrl.start   <= ctrl_wr && wb_wdata[0] && !wb_wdata[1] && !busy;
            ctrl.zeroize <= ctrl_wr && wb_wdata[1];
            if (ctrl_wr) begin
                ctrl.dest_base <= wb_wdata[16 +: `PKD_MEM_AW];
            end
        end
    end

    // Sticky done flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done <= 1'b0;
        end else if (ctrl.start || ctrl.zeroize) begin
            done <= 1'b0;
        end else if (done_pulse) begin
            done <= 1'b1;
        end
    end

    // Read mux, valid in the ack cycle while the master holds the address
    always_comb begin
        wb_rdata = '0;
        case (region)
            `PKD_REGION_REG: begin
                if (wb_adr[11:0] == 12'd1) begin
                    wb_rdata = {30'd0, done, busy};
                end
            end
            `PKD_REGION_KEY: begin
                case (key_wr_slice)
                    2'd0:    wb_rdata = key_rd_word.raw[31:0];
                    2'd1:    wb_rdata = key_rd_word.raw[63:32];
                    2'd2:    wb_rdata = {16'd0, key_rd_word.raw[79:64]};
                    default: wb_rdata = '0;
                endcase
            end
            `PKD_REGION_COEFF: begin
                wb_rdata = 32'(host_rd_coeff);
            end
            default: begin
                wb_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* pk_decode.f */
+incdir+common
common/pk_decode_pkg.sv
design/key_buffer.sv
design/coeff_mem.sv
design/wb_host_regs.sv
pk_decode/pk_decode_fsm.sv
pk_decode/pk_decode_counter.sv
pk_decode/t1_unpack.sv
design/pk_decode_top.sv
tb/pk_decode_tb.sv

/* pk_decode/pk_decode_counter.sv */
// Key read address and coefficient write offset counters for the decode pass
`timescale 1ns/1ps
`default_nettype none
`include "pk_decode_macros.svh"

module pk_decode_counter
    import pk_decode_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  dec_ctrl_t              ctrl,
    input  logic                   rd_active,
    input  logic                   key_rd_valid,
    output logic                   key_rd_en,
    output logic [`PKD_KEY_AW-1:0] key_rd_addr,
    output logic                   read_last,
    output logic [`PKD_MEM_AW-1:0] base_addr,
    output logic [`PKD_MEM_AW-1:0] wr_offset
);

    logic [`PKD_KEY_AW-1:0] rd_count;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_count    <= '0;
            key_rd_en   <= 1'b0;
            key_rd_addr <= '0;
            base_addr   <= '0;
            wr_offset   <= '0;
        end else if (ctrl.zeroize) begin
            rd_count    <= '0;
            key_rd_en   <= 1'b0;
            key_rd_addr <= '0;
            base_addr   <= '0;
            wr_offset   <= '0;
        end else begin
            if (ctrl.start) begin
                base_addr <= ctrl.dest_base;
            end
            // One key word read per READ cycle
            rd_count    <= rd_active ? rd_count + 1'b1 : '0;
            key_rd_en   <= rd_active;
            key_rd_addr <= rd_count;
            // Two memory entries per valid word
            wr_offset   <= key_rd_valid ? wr_offset + `PKD_MEM_AW'(2) : '0;
        end
    end

    assign read_last = rd_active && (rd_count == `PKD_KEY_AW'(`PKD_KEY_WORDS - 1));

endmodule

`default_nettype wire

/* pk_decode/pk_decode_fsm.sv */
// Sequencing FSM for one t1 decode pass, driving the read phase and reporting completion
`timescale 1ns/1ps
`default_nettype none
`include "pk_decode_macros.svh"

module pk_decode_fsm
    import pk_decode_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  dec_ctrl_t ctrl,
    input  logic      read_last,
    input  logic      key_rd_valid,
    output logic      rd_active,
    output logic      busy,
    output logic      done_pulse
);

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b10,
        DONE  = 2'b11
    } state_e;

    state_e state;
    state_e state_next;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else if (ctrl.zeroize) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (ctrl.start) begin
                    state_next = READ;
                end
            end
            READ: begin
                if (read_last) begin
                    state_next = WRITE;
                end
            end
            // Drain the words still in flight through the unpacker
            WRITE: begin
                if (!key_rd_valid) begin
                    state_next = DONE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign rd_active = (state == READ);
    assign busy      = (state != IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done_pulse <= 1'b0;
        end else begin
            done_pulse <= (state == DONE) && !ctrl.zeroize;
        end
    end

endmodule

`default_nettype wire

/* pk_decode/t1_unpack.sv */
// Splits each key word into eight shifted coefficients and issues two registered memory writes
`timescale 1ns/1ps
`default_nettype none
`include "pk_decode_macros.svh"

module t1_unpack
    import pk_decode_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  t1_word_u               key_rd_data,
    input  logic                   key_rd_valid,
    input  logic [`PKD_MEM_AW-1:0] base_addr,
    input  logic [`PKD_MEM_AW-1:0] wr_offset,
    output coeff_quad_t            wr_data_a,
    output coeff_quad_t            wr_data_b,
    output mem_wr_req_t            req_a,
    output mem_wr_req_t            req_b
);

    coeff_quad_t quad_a;
    coeff_quad_t quad_b;

    // 10-bit t1 value times 2^13, top bit stays zero
    function automatic logic [`PKD_COEFF_OUT_W-1:0] shift_coeff(
        input logic [`PKD_COEFF_IN_W-1:0] c
    );
        return `PKD_COEFF_OUT_W'(c) << `PKD_SHIFT;
    endfunction

    // Lanes 0-3 go to port A, lanes 4-7 to port B
    always_comb begin
        for (int i = 0; i < `PKD_LANES/2; i++) begin
            quad_a[i] = shift_coeff(key_rd_data.coeff[i]);
            quad_b[i] = shift_coeff(key_rd_data.coeff[i + `PKD_LANES/2]);
        end
    end

    always_ff @(posedge clk) begin
        if (key_rd_valid) begin
            wr_data_a <= quad_a;
            wr_data_b <= quad_b;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_a <= '0;
            req_b <= '0;
        end else if (zeroize || !key_rd_valid) begin
            req_a <= '0;
            req_b <= '0;
        end else begin
            req_a.wr_en <= 1'b1;
            req_a.addr  <= base_addr + wr_offset;
            req_b.wr_en <= 1'b1;
            req_b.addr  <= base_addr + wr_offset + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the t1 decoder testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module pk_decode_tb \
    -f pk_decode.f \
    -o sim_pk_decode

./obj_dir/sim_pk_decode | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported errors"
    exit 1
fi
echo "Simulation finished without errors"

/* tb/pk_decode_tb.sv */
// Testbench for the t1 decoder, driving the Wishbone host port and checking coefficient readback
`timescale 1ns/1ps
`default_nettype none
`include "pk_decode_macros.svh"

module pk_decode_tb;

    localparam int ACK_TIMEOUT  = 20;
    localparam int POLL_TIMEOUT = 400;
    localparam int N_COEFF      = `PKD_K * `PKD_N;

    logic                  clk;
    logic                  reset_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`PKD_WB_AW-1:0] wb_adr;
    logic [31:0]           wb_wdata;
    logic [31:0]           wb_rdata;
    logic                  wb_ack;

    // Three keys, each 256 packed words of eight 10-bit values
    logic [79:0] keys [3][`PKD_KEY_WORDS];
    integer      seed;
    int          value_errors;
    int          timeout_errors;
    int          coeff_checks;

    // Handoff from the driver to the checker
    logic        chk_valid;
    int          chk_key;
    int          chk_pos;
    int          chk_idx;
    logic [31:0] chk_got;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    pk_decode_top u_pk_decode_top (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    // ==================================================
    // Reference model and address helpers
    // ==================================================
    // Lane pos%8 of word pos/8 times 2^13
    function automatic logic [23:0] expected_coeff(input int key_sel, input int pos);
        logic [79:0] word;
        logic [9:0]  lane_val;
        word     = keys[key_sel][pos / `PKD_LANES];
        lane_val = word[(pos % `PKD_LANES) * `PKD_COEFF_IN_W +: `PKD_COEFF_IN_W];
        return {14'd0, lane_val} << `PKD_SHIFT;
    endfunction

    function automatic logic [13:0] key_addr(input int word, input int slice);
        return {2'd1, 2'd0, 8'(word), 2'(slice)};
    endfunction

    function automatic logic [13:0] coeff_addr(input int idx);
        return {2'd2, 12'(idx)};
    endfunction

    // ==================================================
    // Wishbone driver
    // ==================================================
    task automatic wait_ack(output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            ok = wb_ack;
            cycles++;
        end
    endtask

    task automatic bus_write(input logic [13:0] adr, input logic [31:0] data);
        logic ok;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_wdata = data;
        wait_ack(ok);
        if (!ok) begin
            $display("Timeout: no ack for a write to address %h", adr);
            timeout_errors++;
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input logic [13:0] adr, output logic [31:0] data);
        logic ok;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(ok);
        // Read data is stable mid-cycle while ack is high
        data = wb_rdata;
        if (!ok) begin
            $display("Timeout: no ack for a read from address %h", adr);
            timeout_errors++;
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // ==================================================
    // Test steps
    // ==================================================
    task automatic check_status(input logic [31:0] expected, input string what);
        logic [31:0] data;
        bus_read(14'd1, data);
        if (data !== expected) begin
            $display("FAILED at %0t: %s, status %h expected %h", $time, what, data, expected);
            value_errors++;
        end
    endtask

    task automatic load_key(input int key_sel);
        logic [31:0] r;
        for (int w = 0; w < `PKD_KEY_WORDS; w++) begin
            bus_write(key_addr(w, 0), keys[key_sel][w][31:0]);
            bus_write(key_addr(w, 1), keys[key_sel][w][63:32]);
            // Junk in the upper half must be dropped
            r = $random(seed);
            bus_write(key_addr(w, 2), {r[31:16], keys[key_sel][w][79:64]});
        end
    endtask

    task automatic check_key_word(input int key_sel, input int w);
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] d2;
        bus_read(key_addr(w, 0), d0);
        bus_read(key_addr(w, 1), d1);
        bus_read(key_addr(w, 2), d2);
        if (d0 !== keys[key_sel][w][31:0] || d1 !== keys[key_sel][w][63:32]
                || d2 !== {16'd0, keys[key_sel][w][79:64]}) begin
            $display("FAILED at %0t: key word %0d reads %h %h %h", $time, w, d2, d1, d0);
            value_errors++;
        end
    endtask

    task automatic start_decode(input logic [9:0] base);
        bus_write(14'd0, {6'd0, base, 14'd0, 2'b01});
    endtask

    task automatic wait_done();
        logic [31:0] data;
        int          polls;
        data  = '0;
        polls = 0;
        while (data[1] !== 1'b1 && polls < POLL_TIMEOUT) begin
            bus_read(14'd1, data);
            polls++;
        end
        if (data[1] !== 1'b1) begin
            $display("Timeout: decode did not report done");
            timeout_errors++;
        end else if (data !== 32'd2) begin
            $display("FAILED at %0t: status %h after done, busy still set", $time, data);
            value_errors++;
        end
    endtask

    // Read back one key's worth of coefficients starting at a memory index
    task automatic check_range(input int key_sel, input int base_idx);
        logic [31:0] data;
        for (int pos = 0; pos < N_COEFF; pos++) begin
            bus_read(coeff_addr(base_idx + pos), data);
            chk_key   = key_sel;
            chk_pos   = pos;
            chk_idx   = base_idx + pos;
            chk_got   = data;
            chk_valid = 1'b1;
            @(posedge clk);
            #1;
            chk_valid = 1'b0;
        end
    endtask

    // ==================================================
    // Checker
    // ==================================================
    always @(posedge clk) begin
        if (chk_valid) begin
            coeff_checks++;
            if (chk_got[23:0] !== expected_coeff(chk_key, chk_pos)) begin
                $display("FAILED at %0t: coefficient %0d is %h, expected %h",
                         $time, chk_idx, chk_got[23:0], expected_coeff(chk_key, chk_pos));
                value_errors++;
            end
            if (chk_got[31:23] !== 9'd0 || chk_got[12:0] !== 13'd0) begin
                $display("FAILED at %0t: coefficient %0d has stray bits, %h",
                         $time, chk_idx, chk_got);
                value_errors++;
            end
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        logic [31:0] data;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        seed           = 31334;
        value_errors   = 0;
        timeout_errors = 0;
        coeff_checks   = 0;
        chk_valid      = 1'b0;
        chk_key        = 0;
        chk_pos        = 0;
        chk_idx        = 0;
        chk_got        = '0;
        reset_n        = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_wdata       = '0;
        for (int k = 0; k < 3; k++) begin
            for (int w = 0; w < `PKD_KEY_WORDS; w++) begin
                r0         = $random(seed);
                r1         = $random(seed);
                r2         = $random(seed);
                keys[k][w] = {r2[15:0], r1, r0};
            end
        end
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(posedge clk);
        #1;

        // Idle after reset, coefficient value not defined yet
        check_status(32'd0, "status after reset");
        bus_read(coeff_addr(0), data);

        load_key(0);
        check_key_word(0, 0);
        check_key_word(0, 1);
        check_key_word(0, 127);
        check_key_word(0, 255);

        start_decode(10'd0);
        wait_done();
        check_range(0, 0);

        // Second key at entry 512 which is coefficient 2048
        load_key(1);
        start_decode(10'd512);
        wait_done();
        check_range(1, 2048);
        check_range(0, 0);

        // Abort a decode, then redo it
        load_key(2);
        start_decode(10'd512);
        start_decode(10'd0);
        check_status(32'd1, "busy during decode");
        bus_write(14'd0, 32'h0000_0003);
        check_status(32'd0, "status after zeroize");
        // Longer than a whole decode, so a pass that kept running would raise done
        repeat (`PKD_KEY_WORDS + 20) @(posedge clk);
        #1;
        check_status(32'd0, "done after zeroize");
        start_decode(10'd512);
        wait_done();
        check_range(2, 2048);
        check_range(0, 0);

        $display("Summary: %0d coefficient checks, %0d value errors, %0d timeouts",
                 coeff_checks, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
